/* verilog.f */
dcache_pkg.sv
dcache_ldst_if.sv
dcache_array_if.sv
dcache_io_split.sv
dcache_array.sv
dcache_ctrl.sv
l1_data_cache.sv
tb_l1_data_cache.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --top-module tb_l1_data_cache -f verilog.f -o tb_sim \
	> sim.log 2>&1 || { echo "Verilator build failed, see sim.log"; exit 1; }
./obj_dir/tb_sim >> sim.log 2>&1
grep -q "Testbench failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
echo "PASS"
exit 0

/* tb_l1_data_cache.sv */
module tb_l1_data_cache;

	localparam int INDEX_BITS = 4;
	localparam int LINE_WORDS_LOG2 = 3;
	localparam int LINE_WORDS = 1 << LINE_WORDS_LOG2;
	localparam logic [31:0] SEED = 32'd94985;
	localparam dcache_pkg::addr_t IO_BASE = 32'h8000_0000;
	localparam int TIMEOUT = 200;
	localparam int NUM_OPS = 400;

	logic iCLOCK;
	logic rst;
	logic cache_flush;
	logic iosr_valid;
	dcache_pkg::addr_t iosr;
	logic ldst_req;
	logic ldst_busy;
	logic ldst_rw;
	dcache_pkg::mask_t ldst_mask;
	dcache_pkg::addr_t ldst_addr;
	dcache_pkg::data_t ldst_wdata;
	logic ldst_valid;
	logic ldst_pagefault;
	dcache_pkg::data_t ldst_rdata;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	dcache_pkg::addr_t mem_adr;
	dcache_pkg::mask_t mem_sel;
	dcache_pkg::data_t mem_dat_w;
	dcache_pkg::data_t mem_dat_r = '0;
	logic mem_ack = 1'b0;
	logic mem_err = 1'b0;
	logic io_cyc;
	logic io_stb;
	logic io_we;
	dcache_pkg::addr_t io_adr;
	dcache_pkg::mask_t io_sel;
	dcache_pkg::data_t io_dat_w;
	dcache_pkg::data_t io_dat_r = '0;
	logic io_ack = 1'b0;

	// Bus transfer log, filled by the monitor
	dcache_pkg::addr_t mem_adr_q[$];
	logic mem_we_q[$];
	dcache_pkg::mask_t mem_sel_q[$];
	dcache_pkg::data_t mem_dat_q[$];
	dcache_pkg::addr_t io_adr_q[$];
	logic io_we_q[$];
	dcache_pkg::mask_t io_sel_q[$];
	dcache_pkg::data_t io_dat_q[$];
	int mem_busy_cnt;
	int io_busy_cnt;
	int cycle;

	// Reference model
	logic [31:0] rng_state;
	dcache_pkg::data_t model_mem [1024];
	dcache_pkg::data_t model_io [64];
	logic [15:0] line_valid;
	logic [22:0] line_tag [16];
	int acc_cycle;
	int resp_cycle;
	dcache_pkg::data_t resp_data;
	logic resp_fault;

	// Slave state
	dcache_pkg::data_t mem_arr [1024];
	dcache_pkg::data_t io_arr [64];
	logic [1:0] mem_cnt;
	logic [1:0] mem_dly;
	logic [31:0] mem_rng;
	logic [1:0] io_cnt;
	logic [1:0] io_dly;
	logic [31:0] io_rng;

	l1_data_cache #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS_LOG2(LINE_WORDS_LOG2)) UUT (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_next();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Power-up contents, mixed from the whole word address
	function automatic dcache_pkg::data_t mem_fill(input int unsigned i);
		return (i * 32'h9E37_79B9) ^ 32'h5A3C_0F00;
	endfunction

	function automatic dcache_pkg::data_t io_fill(input int unsigned i);
		return (i * 32'h85EB_CA6B) ^ 32'h0F0F_1234;
	endfunction

	// Only masked byte lanes take the new value
	function automatic dcache_pkg::data_t merge_bytes(input dcache_pkg::data_t old_w,
			input dcache_pkg::data_t new_w, input dcache_pkg::mask_t m);
		dcache_pkg::data_t r;
		r = old_w;
		for (int b = 0; b < 4; b++) begin
			if (m[b]) begin
				r[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return r;
	endfunction

	// 4 tags x 4 indexes, so lines evict each other
	function automatic dcache_pkg::addr_t mem_pick(input logic [31:0] r);
		return {21'd0, r[3:2], 2'd0, r[1:0], r[6:4], 2'd0};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input dcache_pkg::data_t got,
			input dcache_pkg::data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input dcache_pkg::addr_t got,
			input dcache_pkg::addr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_mask(input string name, input dcache_pkg::mask_t got,
			input dcache_pkg::mask_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	initial begin
		iCLOCK = 1'b0;
		forever #20 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		if (rst) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	// Memory slave, err in the fault region
	always @(posedge iCLOCK) begin
		if (rst) begin
			mem_ack <= 1'b0;
			mem_err <= 1'b0;
			mem_cnt <= '0;
			mem_dly <= '0;
			mem_rng <= xorshift(SEED ^ 32'h0000_1357);
			for (int i = 0; i < 1024; i++) begin
				mem_arr[i] <= mem_fill(i);
			end
		end else if (mem_ack || mem_err) begin
			mem_ack <= 1'b0;
			mem_err <= 1'b0;
		end else if (mem_cyc && mem_stb) begin
			if (mem_cnt == mem_dly) begin
				mem_cnt <= '0;
				mem_rng <= xorshift(mem_rng);
				mem_dly <= mem_rng[1:0];
				if (mem_adr[12]) begin
					mem_err <= 1'b1;
				end else begin
					mem_ack <= 1'b1;
					if (mem_we) begin
						mem_arr[mem_adr[11:2]] <= merge_bytes(mem_arr[mem_adr[11:2]],
							mem_dat_w, mem_sel);
					end else begin
						mem_dat_r <= mem_arr[mem_adr[11:2]];
					end
				end
			end else begin
				mem_cnt <= mem_cnt + 1'b1;
			end
		end
	end

	// IO slave, indexed by offset
	always @(posedge iCLOCK) begin
		if (rst) begin
			io_ack <= 1'b0;
			io_cnt <= '0;
			io_dly <= '0;
			io_rng <= xorshift(SEED ^ 32'h0002_4680);
			for (int i = 0; i < 64; i++) begin
				io_arr[i] <= io_fill(i);
			end
		end else if (io_ack) begin
			io_ack <= 1'b0;
		end else if (io_cyc && io_stb) begin
			if (io_cnt == io_dly) begin
				io_cnt <= '0;
				io_rng <= xorshift(io_rng);
				io_dly <= io_rng[1:0];
				io_ack <= 1'b1;
				if (io_we) begin
					io_arr[io_adr[7:2]] <= merge_bytes(io_arr[io_adr[7:2]], io_dat_w, io_sel);
				end else begin
					io_dat_r <= io_arr[io_adr[7:2]];
				end
			end else begin
				io_cnt <= io_cnt + 1'b1;
			end
		end
	end

	// Bus monitor, logs every finished transfer
	always @(negedge iCLOCK) begin
		if (rst) begin
			mem_busy_cnt = 0;
			io_busy_cnt = 0;
		end else begin
			check_flag("mem_stb", mem_stb, mem_cyc);
			check_flag("io_stb", io_stb, io_cyc);
			if (mem_cyc) begin
				mem_busy_cnt++;
			end
			if (io_cyc) begin
				io_busy_cnt++;
			end
			if (mem_cyc && (mem_ack || mem_err)) begin
				mem_adr_q.push_back(mem_adr);
				mem_we_q.push_back(mem_we);
				mem_sel_q.push_back(mem_sel);
				mem_dat_q.push_back(mem_dat_w);
			end
			if (io_cyc && io_ack) begin
				io_adr_q.push_back(io_adr);
				io_we_q.push_back(io_we);
				io_sel_q.push_back(io_sel);
				io_dat_q.push_back(io_dat_w);
			end
		end
	end

	// Hold the request until accepted, then wait for the response strobe
	task automatic run_request(input logic rw, input dcache_pkg::mask_t mask,
			input dcache_pkg::addr_t addr, input dcache_pkg::data_t wdata);
		int t;
		@(posedge iCLOCK);
		ldst_req <= 1'b1;
		ldst_rw <= rw;
		ldst_mask <= mask;
		ldst_addr <= addr;
		ldst_wdata <= wdata;
		t = 0;
		do begin
			@(negedge iCLOCK);
			t++;
			if (t > TIMEOUT) begin
				abort_run("timeout waiting for the request to be accepted");
			end
		end while (ldst_busy);
		acc_cycle = cycle;
		@(posedge iCLOCK);
		ldst_req <= 1'b0;
		t = 0;
		do begin
			@(negedge iCLOCK);
			t++;
			if (t > TIMEOUT) begin
				abort_run("timeout waiting for ldst_valid");
			end
		end while (!ldst_valid);
		resp_cycle = cycle;
		resp_data = ldst_rdata;
		resp_fault = ldst_pagefault;
	endtask

	task automatic mem_access(input logic rw, input dcache_pkg::addr_t addr,
			input dcache_pkg::mask_t mask, input dcache_pkg::data_t wdata);
		logic [3:0] idx;
		logic cached;
		logic fault;
		dcache_pkg::addr_t base;
		int mb;
		int mc;
		int ic;
		idx = addr[8:5];
		cached = line_valid[idx] && (line_tag[idx] == addr[31:9]);
		fault = addr[12];
		base = {addr[31:5], 5'd0};
		mb = mem_adr_q.size();
		mc = mem_busy_cnt;
		ic = io_busy_cnt;
		run_request(rw, mask, addr, wdata);
		if (io_busy_cnt != ic) begin
			abort_run("memory request showed up on the IO bus");
		end
		check_flag("ldst_pagefault", resp_fault, fault);
		if (!rw) begin
			// Write-through, line state untouched
			if (mem_adr_q.size() != mb + 1) begin
				abort_run("write did not make exactly one memory transfer");
			end
			check_addr("mem_adr", mem_adr_q[mb], {addr[31:2], 2'd0});
			check_flag("mem_we", mem_we_q[mb], 1'b1);
			check_mask("mem_sel", mem_sel_q[mb], mask);
			check_data("mem_dat_w", mem_dat_q[mb], wdata);
			if (!fault) begin
				model_mem[addr[11:2]] = merge_bytes(model_mem[addr[11:2]], wdata, mask);
			end
		end else if (fault) begin
			// Err on the first word ends the refill and drops the line
			if (mem_adr_q.size() != mb + 1) begin
				abort_run("faulting refill did not stop at its first word");
			end
			check_addr("mem_adr", mem_adr_q[mb], base);
			line_valid[idx] = 1'b0;
		end else if (cached) begin
			if (mem_busy_cnt != mc) begin
				abort_run("read hit started a memory transfer");
			end
			if (resp_cycle - acc_cycle != 2) begin
				abort_run("read hit did not respond two cycles after acceptance");
			end
			check_data("ldst_rdata", resp_data, model_mem[addr[11:2]]);
		end else begin
			if (mem_adr_q.size() != mb + LINE_WORDS) begin
				abort_run("refill did not read every word of the line once");
			end
			// Line base upward
			for (int k = 0; k < LINE_WORDS; k++) begin
				check_addr("mem_adr", mem_adr_q[mb + k], base + dcache_pkg::addr_t'(4 * k));
				check_flag("mem_we", mem_we_q[mb + k], 1'b0);
				check_mask("mem_sel", mem_sel_q[mb + k], 4'hF);
			end
			check_data("ldst_rdata", resp_data, model_mem[addr[11:2]]);
			line_valid[idx] = 1'b1;
			line_tag[idx] = addr[31:9];
		end
	endtask

	task automatic io_access(input logic rw, input dcache_pkg::addr_t off,
			input dcache_pkg::mask_t mask, input dcache_pkg::data_t wdata);
		int ib;
		int mc;
		ib = io_adr_q.size();
		mc = mem_busy_cnt;
		run_request(rw, mask, IO_BASE + off, wdata);
		if (mem_busy_cnt != mc) begin
			abort_run("IO request showed up on the memory bus");
		end
		if (io_adr_q.size() != ib + 1) begin
			abort_run("IO request did not make exactly one IO transfer");
		end
		check_addr("io_adr", io_adr_q[ib], off);
		check_flag("io_we", io_we_q[ib], !rw);
		check_mask("io_sel", io_sel_q[ib], mask);
		check_flag("ldst_pagefault", resp_fault, 1'b0);
		if (rw) begin
			check_data("ldst_rdata", resp_data, model_io[off[7:2]]);
		end else begin
			check_data("io_dat_w", io_dat_q[ib], wdata);
			model_io[off[7:2]] = merge_bytes(model_io[off[7:2]], wdata, mask);
		end
	endtask

	task automatic flush_cache();
		@(posedge iCLOCK);
		cache_flush <= 1'b1;
		@(posedge iCLOCK);
		cache_flush <= 1'b0;
		line_valid = '0;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		dcache_pkg::data_t d;
		dcache_pkg::mask_t m;
		rst <= 1'b1;
		cache_flush <= 1'b0;
		iosr_valid <= 1'b0;
		iosr <= '0;
		ldst_req <= 1'b0;
		ldst_rw <= 1'b1;
		ldst_mask <= '0;
		ldst_addr <= '0;
		ldst_wdata <= '0;
		rng_state = SEED;
		line_valid = '0;
		for (int i = 0; i < 1024; i++) begin
			model_mem[i] = mem_fill(i);
		end
		for (int i = 0; i < 64; i++) begin
			model_io[i] = io_fill(i);
		end
		repeat (4) @(posedge iCLOCK);
		rst <= 1'b0;
		// Outputs quiet, and busy until the IO window is known
		repeat (3) begin
			@(negedge iCLOCK);
			check_flag("ldst_busy", ldst_busy, 1'b1);
			check_flag("ldst_valid", ldst_valid, 1'b0);
			check_flag("mem_cyc", mem_cyc, 1'b0);
			check_flag("io_cyc", io_cyc, 1'b0);
		end
		@(posedge iCLOCK);
		iosr <= IO_BASE;
		iosr_valid <= 1'b1;
		@(posedge iCLOCK);
		iosr_valid <= 1'b0;

		// Miss, hit, write into a present line, flush, refill
		mem_access(1'b1, 32'h0000_0000, 4'hF, '0);
		mem_access(1'b1, 32'h0000_0000, 4'hF, '0);
		mem_access(1'b0, 32'h0000_0004, 4'b0101, 32'h1122_3344);
		mem_access(1'b1, 32'h0000_0004, 4'hF, '0);
		flush_cache();
		mem_access(1'b1, 32'h0000_0004, 4'hF, '0);
		// Repeated fault, and a fault evicting the line at its index
		mem_access(1'b1, 32'h0000_0020, 4'hF, '0);
		mem_access(1'b1, 32'h0000_1020, 4'hF, '0);
		mem_access(1'b1, 32'h0000_1020, 4'hF, '0);
		mem_access(1'b1, 32'h0000_0020, 4'hF, '0);
		io_access(1'b0, 32'h0000_000C, 4'b1100, 32'hDEAD_0000);
		io_access(1'b1, 32'h0000_000C, 4'hF, '0);

		for (int n = 0; n < NUM_OPS; n++) begin
			r = rand_next();
			a = rand_next();
			d = rand_next();
			m = a[11:8];
			if (m == '0) begin
				m = 4'hF;
			end
			case (r[2:0])
				3'd0, 3'd1, 3'd2: mem_access(1'b1, mem_pick(a), m, d);
				3'd3, 3'd4: mem_access(1'b0, mem_pick(a), m, d);
				3'd5: mem_access(r[3], mem_pick(a) | 32'h0000_1000, m, d);
				3'd6: io_access(r[3], {24'd0, a[7:2], 2'd0}, m, d);
				default: begin
					if (r[6:4] == 3'd0) begin
						flush_cache();
					end else begin
						mem_access(1'b1, mem_pick(a), m, d);
					end
				end
			endcase
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

/* l1_data_cache.sv */
module l1_data_cache #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS_LOG2 = 3
) (
	input logic iCLOCK,
	input logic rst,
	input logic cache_flush,
	// IO window start from system info
	input logic iosr_valid,
	input dcache_pkg::addr_t iosr,
	// Load/store unit
	input logic ldst_req,
	output logic ldst_busy,
	// 1 = read
	input logic ldst_rw,
	input dcache_pkg::mask_t ldst_mask,
	input dcache_pkg::addr_t ldst_addr,
	input dcache_pkg::data_t ldst_wdata,
	output logic ldst_valid,
	output logic ldst_pagefault,
	output dcache_pkg::data_t ldst_rdata,
	// Memory Wishbone master
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output dcache_pkg::addr_t mem_adr,
	output dcache_pkg::mask_t mem_sel,
	output dcache_pkg::data_t mem_dat_w,
	input dcache_pkg::data_t mem_dat_r,
	input logic mem_ack,
	input logic mem_err,
	// IO Wishbone master
	output logic io_cyc,
	output logic io_stb,
	output logic io_we,
	output dcache_pkg::addr_t io_adr,
	output dcache_pkg::mask_t io_sel,
	output dcache_pkg::data_t io_dat_w,
	input dcache_pkg::data_t io_dat_r,
	input logic io_ack
);

	// Splitter to controller
	dcache_ldst_if ldst_bus ();
	// Controller to storage
	dcache_array_if arr_bus ();

	dcache_io_split u_io_split (
		.iCLOCK(iCLOCK), .rst(rst), .iosr_valid(iosr_valid), .iosr(iosr),
		.ldst_req(ldst_req), .ldst_busy(ldst_busy), .ldst_rw(ldst_rw),
		.ldst_mask(ldst_mask), .ldst_addr(ldst_addr), .ldst_wdata(ldst_wdata),
		.ldst_valid(ldst_valid), .ldst_pagefault(ldst_pagefault), .ldst_rdata(ldst_rdata),
		.io_cyc(io_cyc), .io_stb(io_stb), .io_we(io_we), .io_adr(io_adr),
		.io_sel(io_sel), .io_dat_w(io_dat_w), .io_dat_r(io_dat_r), .io_ack(io_ack),
		.back(ldst_bus.front)
	);

	dcache_ctrl #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS_LOG2(LINE_WORDS_LOG2)) u_ctrl (
		.iCLOCK(iCLOCK), .rst(rst), .ldst(ldst_bus.back), .arr(arr_bus.ctrl),
		.mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
		.mem_sel(mem_sel), .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r),
		.mem_ack(mem_ack), .mem_err(mem_err)
	);

	dcache_array #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS_LOG2(LINE_WORDS_LOG2)) u_array (
		.iCLOCK(iCLOCK), .rst(rst), .cache_flush(cache_flush), .port(arr_bus.store)
	);

endmodule

/* dcache_ctrl.sv */
module dcache_ctrl #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS_LOG2 = 3
) (
	input logic iCLOCK,
	input logic rst,
	dcache_ldst_if.back ldst,
	dcache_array_if.ctrl arr,
	// Memory Wishbone master
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output dcache_pkg::addr_t mem_adr,
	output dcache_pkg::mask_t mem_sel,
	output dcache_pkg::data_t mem_dat_w,
	input dcache_pkg::data_t mem_dat_r,
	input logic mem_ack,
	input logic mem_err
);

	localparam int OFFS_BITS = LINE_WORDS_LOG2 + 2;
	// Tag plus index, the line base
	localparam int BASE_BITS = dcache_pkg::ADDR_W - OFFS_BITS;

	dcache_pkg::ctrl_state_t state;
	// Captured request
	dcache_pkg::req_kind_t req_kind;
	dcache_pkg::mask_t req_mask;
	dcache_pkg::addr_t req_addr;
	dcache_pkg::data_t req_wdata;
	// Refill word counter
	logic [LINE_WORDS_LOG2-1:0] word_cnt;
	logic [LINE_WORDS_LOG2-1:0] req_word;
	dcache_pkg::data_t resp_data;
	logic resp_fault;
	logic bus_done;
	logic fill_ok;

	assign req_word = req_addr[2 +: LINE_WORDS_LOG2];
	assign bus_done = mem_cyc && (mem_ack || mem_err);
	// Error has priority over ack
	assign fill_ok = mem_cyc && mem_ack && !mem_err;

	assign ldst.busy = state != dcache_pkg::IDLE;
	assign ldst.valid = state == dcache_pkg::RESPOND;
	assign ldst.rdata = resp_data;
	assign ldst.pagefault = resp_fault;

	// Lookup on the accept cycle, result in LOOKUP
	assign arr.lookup_en = (state == dcache_pkg::IDLE) && ldst.req;
	assign arr.lookup_addr = ldst.addr;

	// Refill words straight from the bus, also on err to keep the line invalid
	assign arr.fill_we = (state == dcache_pkg::FILL_WAIT) && bus_done;
	assign arr.fill_addr = mem_adr;
	assign arr.fill_data = mem_dat_r;
	assign arr.fill_valid_set = (state == dcache_pkg::FILL_WAIT) && fill_ok && (&word_cnt);

	// Write-through update lands with the response
	assign arr.upd_we = (state == dcache_pkg::RESPOND) && (req_kind == dcache_pkg::WRITE)
		&& !resp_fault;
	assign arr.upd_addr = req_addr;
	assign arr.upd_mask = req_mask;
	assign arr.upd_data = req_wdata;

	// FSM and bus handshake
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			state <= dcache_pkg::IDLE;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
			word_cnt <= '0;
			resp_fault <= 1'b0;
		end else begin
			case (state)
				dcache_pkg::IDLE: begin
					if (ldst.req) begin
						state <= dcache_pkg::LOOKUP;
						word_cnt <= '0;
						resp_fault <= 1'b0;
					end
				end
				dcache_pkg::LOOKUP: begin
					if (req_kind == dcache_pkg::WRITE) begin
						state <= dcache_pkg::WR_REQ;
					end else if (arr.hit) begin
						state <= dcache_pkg::RESPOND;
					end else begin
						state <= dcache_pkg::FILL_REQ;
					end
				end
				dcache_pkg::FILL_REQ: begin
					mem_cyc <= 1'b1;
					mem_stb <= 1'b1;
					state <= dcache_pkg::FILL_WAIT;
				end
				dcache_pkg::FILL_WAIT: begin
					if (bus_done) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						if (mem_err) begin
							// Page fault aborts the refill
							resp_fault <= 1'b1;
							state <= dcache_pkg::RESPOND;
						end else if (&word_cnt) begin
							state <= dcache_pkg::RESPOND;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state <= dcache_pkg::FILL_REQ;
						end
					end
				end
				dcache_pkg::WR_REQ: begin
					mem_cyc <= 1'b1;
					mem_stb <= 1'b1;
					state <= dcache_pkg::WR_WAIT;
				end
				dcache_pkg::WR_WAIT: begin
					if (bus_done) begin
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
						resp_fault <= mem_err;
						state <= dcache_pkg::RESPOND;
					end
				end
				default: begin
					state <= dcache_pkg::IDLE;
				end
			endcase
		end
	end

	// Request capture, bus payload and read data
	always_ff @(posedge iCLOCK) begin
		case (state)
			dcache_pkg::IDLE: begin
				if (ldst.req) begin
					req_kind <= ldst.kind;
					req_mask <= ldst.mask;
					req_addr <= ldst.addr;
					req_wdata <= ldst.wdata;
				end
			end
			dcache_pkg::LOOKUP: begin
				resp_data <= arr.hit_data;
			end
			dcache_pkg::FILL_REQ: begin
				// Line base upward, one word per transfer
				mem_we <= 1'b0;
				mem_adr <= {req_addr[OFFS_BITS +: BASE_BITS], word_cnt, 2'b00};
				mem_sel <= '1;
			end
			dcache_pkg::FILL_WAIT: begin
				// Keep the requested word
				if (fill_ok && (word_cnt == req_word)) begin
					resp_data <= mem_dat_r;
				end
			end
			dcache_pkg::WR_REQ: begin
				mem_we <= 1'b1;
				mem_adr <= {req_addr[dcache_pkg::ADDR_W-1:2], 2'b00};
				mem_sel <= req_mask;
				mem_dat_w <= req_wdata;
			end
			default: begin
			end
		endcase
	end

endmodule

/* dcache_array.sv */
module dcache_array #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS_LOG2 = 3
) (
	input logic iCLOCK,
	input logic rst,
	input logic cache_flush,
	dcache_array_if.store port
);

	localparam int LINES = 1 << INDEX_BITS;
	// Byte offset within a line
	localparam int OFFS_BITS = LINE_WORDS_LOG2 + 2;
	localparam int TAG_LSB = OFFS_BITS + INDEX_BITS;
	localparam int TAG_BITS = dcache_pkg::ADDR_W - TAG_LSB;
	// Word slot is {index, word}
	localparam int SLOT_BITS = INDEX_BITS + LINE_WORDS_LOG2;

	logic [TAG_BITS-1:0] tag_mem [LINES];
	logic [LINES-1:0] valid;
	dcache_pkg::data_t data_mem [1 << SLOT_BITS];

	logic [INDEX_BITS-1:0] lk_idx;
	logic [INDEX_BITS-1:0] fl_idx;
	logic [INDEX_BITS-1:0] up_idx;
	logic [SLOT_BITS-1:0] lk_slot;
	logic [SLOT_BITS-1:0] fl_slot;
	logic [SLOT_BITS-1:0] up_slot;
	logic [TAG_BITS-1:0] lk_tag;
	logic [TAG_BITS-1:0] fl_tag;
	logic [TAG_BITS-1:0] up_tag;
	logic up_match;

	// Address fields of the three ports
	assign lk_idx = port.lookup_addr[OFFS_BITS +: INDEX_BITS];
	assign fl_idx = port.fill_addr[OFFS_BITS +: INDEX_BITS];
	assign up_idx = port.upd_addr[OFFS_BITS +: INDEX_BITS];
	assign lk_slot = port.lookup_addr[2 +: SLOT_BITS];
	assign fl_slot = port.fill_addr[2 +: SLOT_BITS];
	assign up_slot = port.upd_addr[2 +: SLOT_BITS];
	assign lk_tag = port.lookup_addr[TAG_LSB +: TAG_BITS];
	assign fl_tag = port.fill_addr[TAG_LSB +: TAG_BITS];
	assign up_tag = port.upd_addr[TAG_LSB +: TAG_BITS];

	// Write-through only touches a line that is present
	assign up_match = valid[up_idx] && (tag_mem[up_idx] == up_tag);

	// Valid bits and hit flag
	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			valid <= '0;
			port.hit <= 1'b0;
		end else begin
			if (port.lookup_en) begin
				port.hit <= valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
			end
			// Line stays invalid until its last word lands
			if (port.fill_we) begin
				valid[fl_idx] <= port.fill_valid_set;
			end
			// Flush wins over a concurrent fill
			if (cache_flush) begin
				valid <= '0;
			end
		end
	end

	// Tag and word storage
	always_ff @(posedge iCLOCK) begin
		if (port.lookup_en) begin
			port.hit_data <= data_mem[lk_slot];
		end
		if (port.fill_we) begin
			data_mem[fl_slot] <= port.fill_data;
		end
		if (port.fill_we && port.fill_valid_set) begin
			tag_mem[fl_idx] <= fl_tag;
		end
		// Byte lanes selected by the mask
		if (port.upd_we && up_match) begin
			for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
				if (port.upd_mask[b]) begin
					data_mem[up_slot][b*dcache_pkg::BYTE_W +: dcache_pkg::BYTE_W] <=
						port.upd_data[b*dcache_pkg::BYTE_W +: dcache_pkg::BYTE_W];
				end
			end
		end
	end

endmodule

/* dcache_io_split.sv */
module dcache_io_split (
	input logic iCLOCK,
	input logic rst,
	input logic iosr_valid,
	input dcache_pkg::addr_t iosr,
	// Load/store unit
	input logic ldst_req,
	output logic ldst_busy,
	input logic ldst_rw,
	input dcache_pkg::mask_t ldst_mask,
	input dcache_pkg::addr_t ldst_addr,
	input dcache_pkg::data_t ldst_wdata,
	output logic ldst_valid,
	output logic ldst_pagefault,
	output dcache_pkg::data_t ldst_rdata,
	// IO Wishbone master
	output logic io_cyc,
	output logic io_stb,
	output logic io_we,
	output dcache_pkg::addr_t io_adr,
	output dcache_pkg::mask_t io_sel,
	output dcache_pkg::data_t io_dat_w,
	input dcache_pkg::data_t io_dat_r,
	input logic io_ack,
	dcache_ldst_if.front back
);

	// IO start address, loaded from system info
	logic io_start_valid;
	dcache_pkg::addr_t io_start;
	// IO response strobe and its data
	logic io_done;
	dcache_pkg::data_t io_rdata;
	logic accept;
	logic is_io;

	assign accept = ldst_req && !ldst_busy;
	// Single compare per accepted request
	assign is_io = ldst_addr >= io_start;

	// Blocked until the IO window is known, and while either side works
	assign ldst_busy = !io_start_valid || io_cyc || io_done || back.busy;

	// Memory requests go straight to the controller
	assign back.req = accept && !is_io;
	assign back.kind = dcache_pkg::req_kind_t'(ldst_rw);
	assign back.mask = ldst_mask;
	assign back.addr = ldst_addr;
	assign back.wdata = ldst_wdata;

	// Merge the two response paths
	assign ldst_valid = io_done || back.valid;
	assign ldst_rdata = io_done ? io_rdata : back.rdata;
	// IO bus has no error line
	assign ldst_pagefault = io_done ? 1'b0 : back.pagefault;

	always_ff @(posedge iCLOCK) begin
		if (rst) begin
			io_start_valid <= 1'b0;
			io_cyc <= 1'b0;
			io_stb <= 1'b0;
			io_done <= 1'b0;
		end else begin
			if (iosr_valid) begin
				io_start_valid <= 1'b1;
			end
			io_done <= 1'b0;
			if (accept && is_io) begin
				io_cyc <= 1'b1;
				io_stb <= 1'b1;
			end else if (io_cyc && io_ack) begin
				io_cyc <= 1'b0;
				io_stb <= 1'b0;
				io_done <= 1'b1;
			end
		end
	end

	// IO transfer payload, offset into the IO window
	always_ff @(posedge iCLOCK) begin
		if (iosr_valid) begin
			io_start <= iosr;
		end
		if (accept && is_io) begin
			io_we <= !ldst_rw;
			io_adr <= ldst_addr - io_start;
			io_sel <= ldst_mask;
			io_dat_w <= ldst_wdata;
		end
		if (io_cyc && io_ack) begin
			io_rdata <= io_dat_r;
		end
	end

endmodule

/* dcache_array_if.sv */
interface dcache_array_if;

	// Lookup port
	logic lookup_en;
	dcache_pkg::addr_t lookup_addr;
	// Registered result of the lookup
	logic hit;
	dcache_pkg::data_t hit_data;

	// Refill word write
	logic fill_we;
	dcache_pkg::addr_t fill_addr;
	dcache_pkg::data_t fill_data;
	// Last fill word, line becomes valid
	logic fill_valid_set;

	// Write-through update of a present line
	logic upd_we;
	dcache_pkg::addr_t upd_addr;
	dcache_pkg::mask_t upd_mask;
	dcache_pkg::data_t upd_data;

	modport ctrl (
		output lookup_en, lookup_addr, fill_we, fill_addr, fill_data, fill_valid_set,
		output upd_we, upd_addr, upd_mask, upd_data,
		input hit, hit_data
	);

	modport store (
		input lookup_en, lookup_addr, fill_we, fill_addr, fill_data, fill_valid_set,
		input upd_we, upd_addr, upd_mask, upd_data,
		output hit, hit_data
	);

endinterface

/* dcache_ldst_if.sv */
interface dcache_ldst_if;

	// Request, front to back
	logic req;
	dcache_pkg::req_kind_t kind;
	dcache_pkg::mask_t mask;
	dcache_pkg::addr_t addr;
	dcache_pkg::data_t wdata;

	// Response, back to front
	logic busy;
	logic valid;
	logic pagefault;
	dcache_pkg::data_t rdata;

	// Request side, the address splitter
	modport front (
		output req, kind, mask, addr, wdata,
		input busy, valid, pagefault, rdata
	);

	// Cache controller side
	modport back (
		input req, kind, mask, addr, wdata,
		output busy, valid, pagefault, rdata
	);

endinterface

/* dcache_pkg.sv */
package dcache_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int BYTE_W = 8;
	localparam int MASK_W = DATA_W / BYTE_W;

	// Byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// One data word
	typedef logic [DATA_W-1:0] data_t;

	// One enable bit per byte lane
	typedef logic [MASK_W-1:0] mask_t;

	// Controller states
	typedef enum logic [2:0] {
		// Waiting for a request
		IDLE,
		// Tag compare result available
		LOOKUP,
		// Start one refill word
		FILL_REQ,
		// Wait for refill ack or err
		FILL_WAIT,
		// One-cycle response strobe
		RESPOND,
		// Start the write-through
		WR_REQ,
		// Wait for write ack or err
		WR_WAIT
	} ctrl_state_t;

	// Request kinds, rw encoding of the load/store unit
	typedef enum logic {
		WRITE = 1'b0,
		READ = 1'b1
	} req_kind_t;

endpackage
